// File: Makefile
TOP = prbs_bist_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f prbs_bist.f -o V$(TOP)

# the output is scanned for the pass message, the status follows grep
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only --timing -Wall --top-module prbs_bist_top -f prbs_bist.f

clean:
	rm -rf obj_dir

// File: design/prbs_bist_pkg.sv
`default_nettype none

package prbs_bist_pkg;

    ////////////////////
    // widths

    localparam int LFSR_W = 16;  // link word and lfsr width
    localparam int TAP_W  = 5;   // bits per tap position, 0 = unused
    localparam int TAP_N  = 4;   // tap positions per command
    localparam int CNT_W  = 16;  // counts and word indices

    // first_err value when the run was clean
    localparam logic [CNT_W-1:0] NO_ERR = '1;

    ////////////////////
    // command and result

    typedef enum logic {
        MODE_RUN    = 1'b0,  // send exactly count words
        MODE_PERIOD = 1'b1   // stop at first return to seed, or at count
    } bist_mode_e;

    // host -> engine
    typedef struct packed {
        bist_mode_e             mode;
        logic [LFSR_W-1:0]      seed;
        logic [TAP_N*TAP_W-1:0] taps;   // tap 0 in the low bits
        logic [CNT_W-1:0]       count;  // words to send, upper bound in period mode
    } test_cmd_t;

    // engine -> host
    typedef struct packed {
        logic             wrapped;    // generator came back to the seed
        logic [CNT_W-1:0] steps;      // words actually sent
        logic [CNT_W-1:0] err_count;  // mismatching rx words
        logic [CNT_W-1:0] first_err;  // index of first mismatch or NO_ERR
    } test_result_t;

endpackage : prbs_bist_pkg

`default_nettype wire

// File: design/prbs_bist_top.sv
`default_nettype none

// bist engine with controller, generator lfsr and loopback checker
module prbs_bist_top (
    input  wire logic                             i_clk,
    input  wire logic                             i_rst_n,
    // command port
    input  wire logic                             i_cmd_req,
    input  wire prbs_bist_pkg::test_cmd_t         i_cmd,
    output logic                                  o_cmd_ack,
    // result port
    output logic                                  o_res_req,
    input  wire logic                             i_res_ack,
    output prbs_bist_pkg::test_result_t           o_res,
    // link
    output logic                                  o_tx_valid,
    output logic [prbs_bist_pkg::LFSR_W-1:0]      o_tx_data,
    input  wire logic [prbs_bist_pkg::LFSR_W-1:0] i_rx_data
);
    import prbs_bist_pkg::*;

    ////////////////////
    // internal wires

    logic                   lfsr_en;     // step or load for both lfsrs
    logic                   lfsr_load;   // seed load for both lfsrs
    logic [LFSR_W-1:0]      seed;
    logic [TAP_N*TAP_W-1:0] taps;
    logic [LFSR_W-1:0]      gen_state;   // current tx word
    logic                   gen_done;    // generator at seed
    logic [CNT_W-1:0]       err_count;
    logic [CNT_W-1:0]       first_err;

    prbs_ctrl u_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_req   (i_cmd_req),
        .i_cmd       (i_cmd),
        .o_cmd_ack   (o_cmd_ack),
        .o_res_req   (o_res_req),
        .i_res_ack   (i_res_ack),
        .o_res       (o_res),
        .o_lfsr_en   (lfsr_en),
        .o_lfsr_load (lfsr_load),
        .o_seed      (seed),
        .o_taps      (taps),
        .i_gen_state (gen_state),
        .i_gen_done  (gen_done),
        .i_err_count (err_count),
        .i_first_err (first_err),
        .o_tx_valid  (o_tx_valid),
        .o_tx_data   (o_tx_data)
    );

    // generator lfsr drives the tx words
    shifter_lfsr #(
        .WIDTH           (LFSR_W),
        .TAP_INDEX_WIDTH (TAP_W),
        .TAP_COUNT       (TAP_N)
    ) u_gen_lfsr (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (lfsr_en),
        .i_seed_load  (lfsr_load),
        .i_seed_data  (seed),
        .i_taps       (taps),
        .o_lfsr_out   (gen_state),
        .ow_lfsr_done (gen_done)
    );

    prbs_checker u_chk (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_load      (lfsr_load),
        .i_valid     (o_tx_valid),   // rx sampled together with tx valid
        .i_seed      (seed),
        .i_taps      (taps),
        .i_rx_data   (i_rx_data),
        .o_err_count (err_count),
        .o_first_err (first_err)
    );

endmodule : prbs_bist_top

`default_nettype wire

// File: design/prbs_checker.sv
`default_nettype none

// predicts rx words with its own lfsr and counts mismatches
module prbs_checker (
    input  wire logic                                        i_clk,
    input  wire logic                                        i_rst_n,
    input  wire logic                                        i_load,     // seed load and count clear
    input  wire logic                                        i_valid,    // rx word present
    input  wire logic [prbs_bist_pkg::LFSR_W-1:0]            i_seed,
    input  wire logic [prbs_bist_pkg::TAP_N*prbs_bist_pkg::TAP_W-1:0] i_taps,
    input  wire logic [prbs_bist_pkg::LFSR_W-1:0]            i_rx_data,
    output logic      [prbs_bist_pkg::CNT_W-1:0]             o_err_count,
    output logic      [prbs_bist_pkg::CNT_W-1:0]             o_first_err
);
    import prbs_bist_pkg::*;

    logic [LFSR_W-1:0] w_expect;    // predicted word
    logic [CNT_W-1:0]  r_idx;       // index of current rx word
    logic              w_mismatch;

    ////////////////////
    // reference sequence

    // steps in lockstep with the generator lfsr
    shifter_lfsr #(
        .WIDTH           (LFSR_W),
        .TAP_INDEX_WIDTH (TAP_W),
        .TAP_COUNT       (TAP_N)
    ) ref_lfsr (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_enable     (i_load || i_valid),
        .i_seed_load  (i_load),
        .i_seed_data  (i_seed),
        .i_taps       (i_taps),
        .o_lfsr_out   (w_expect),
        .ow_lfsr_done ()              // wrap is tracked on the generator side
    );

    assign w_mismatch = i_valid && (i_rx_data != w_expect);

    ////////////////////
    // counters

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_idx       <= '0;
            o_err_count <= '0;
            o_first_err <= NO_ERR;
        end else if (i_load) begin
            r_idx       <= '0;      // new run
            o_err_count <= '0;
            o_first_err <= NO_ERR;
        end else if (i_valid) begin
            r_idx <= r_idx + 1'b1;
            if (w_mismatch) begin
                o_err_count <= o_err_count + 1'b1;
                if (o_err_count == '0) o_first_err <= r_idx;        // keep only first
            end
        end
    end

endmodule : prbs_checker

`default_nettype wire

// File: design/prbs_ctrl.sv
`default_nettype none

// run sequencing for one bist command, both four-phase ports
module prbs_ctrl (
    input  wire logic                                        i_clk,
    input  wire logic                                        i_rst_n,
    // command port, host is requester
    input  wire logic                                        i_cmd_req,
    input  wire prbs_bist_pkg::test_cmd_t                    i_cmd,
    output logic                                             o_cmd_ack,
    // result port, engine is requester
    output logic                                             o_res_req,
    input  wire logic                                        i_res_ack,
    output prbs_bist_pkg::test_result_t                      o_res,
    // generator and checker lfsr control
    output logic                                             o_lfsr_en,
    output logic                                             o_lfsr_load,
    output logic [prbs_bist_pkg::LFSR_W-1:0]                 o_seed,
    output logic [prbs_bist_pkg::TAP_N*prbs_bist_pkg::TAP_W-1:0] o_taps,
    input  wire logic [prbs_bist_pkg::LFSR_W-1:0]            i_gen_state,
    input  wire logic                                        i_gen_done,
    // checker status
    input  wire logic [prbs_bist_pkg::CNT_W-1:0]             i_err_count,
    input  wire logic [prbs_bist_pkg::CNT_W-1:0]             i_first_err,
    // link
    output logic                                             o_tx_valid,
    output logic [prbs_bist_pkg::LFSR_W-1:0]                 o_tx_data
);
    import prbs_bist_pkg::*;

    typedef enum logic [2:0] {
        IDLE,    // waiting for a command
        ACK,     // result done, waiting for host to drop cmd req
        LOAD,    // both lfsrs take the seed
        RUN,     // one word per cycle
        RESULT,  // res req high, waiting for ack
        REL      // waiting for ack to drop
    } state_e;

    state_e           r_state;
    test_cmd_t        r_cmd;        // latched command, held for whole run
    logic [CNT_W-1:0] r_cnt;        // words sent so far
    logic [CNT_W-1:0] w_cnt_nxt;
    logic             r_res_req;
    logic             w_period;
    logic             w_wrap_stop;  // generator back at seed, this word not sent
    logic             w_last_word;  // current word reaches count

    ////////////////////
    // stop conditions

    assign w_period  = (r_cmd.mode == MODE_PERIOD);
    assign w_cnt_nxt = r_cnt + 1'b1;

    // word 0 is the seed itself, so only k >= 1 counts as a wrap
    assign w_wrap_stop = (r_state == RUN) && w_period && (r_cnt != '0) && i_gen_done;
    assign w_last_word = (w_cnt_nxt == r_cmd.count);

    ////////////////////
    // fsm

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_state   <= IDLE;
            r_cmd     <= '0;
            r_cnt     <= '0;
            r_res_req <= 1'b0;
            o_cmd_ack <= 1'b0;
        end else begin
            // ack falls once the host has let go of req
            if (o_cmd_ack && !i_cmd_req) begin
                o_cmd_ack <= 1'b0;
            end

            case (r_state)
                IDLE: begin
                    if (i_cmd_req && !o_cmd_ack) begin
                        r_cmd     <= i_cmd;  // cycle 0
                        r_cnt     <= '0;
                        o_cmd_ack <= 1'b1;
                        r_state   <= LOAD;
                    end
                end
                LOAD: begin
                    if (r_cmd.count == '0) begin
                        r_res_req <= 1'b1;   // nothing to send
                        r_state   <= RESULT;
                    end else begin
                        r_state <= RUN;
                    end
                end
                RUN: begin
                    if (w_wrap_stop) begin
                        r_res_req <= 1'b1;   // req already shown combinationally
                        r_state   <= RESULT;
                    end else begin
                        r_cnt <= w_cnt_nxt;
                        if (w_last_word) begin
                            r_res_req <= 1'b1;
                            r_state   <= RESULT;
                        end
                    end
                end
                RESULT: begin
                    if (i_res_ack) begin
                        r_res_req <= 1'b0;
                        r_state   <= REL;
                    end
                end
                REL: begin
                    if (!i_res_ack) begin
                        r_state <= o_cmd_ack ? ACK : IDLE;
                    end
                end
                ACK: begin
                    if (!o_cmd_ack) r_state <= IDLE;  // cmd handshake back to zero
                end
                default: r_state <= IDLE;
            endcase
        end
    end

    ////////////////////
    // outputs

    assign o_tx_valid  = (r_state == RUN) && !w_wrap_stop;
    assign o_tx_data   = i_gen_state;                 // word k = state after k steps
    assign o_lfsr_load = (r_state == LOAD);
    assign o_lfsr_en   = o_lfsr_load || o_tx_valid;   // step once per sent word
    assign o_seed      = r_cmd.seed;
    assign o_taps      = r_cmd.taps;

    // wrap case raises req in the cycle right after the last word
    assign o_res_req = r_res_req || w_wrap_stop;

    // generator is frozen after the run, so done stays valid here
    always_comb begin
        o_res.wrapped   = w_period && (r_cnt != '0) && i_gen_done;
        o_res.steps     = r_cnt;
        o_res.err_count = i_err_count;
        o_res.first_err = i_first_err;
    end

endmodule : prbs_ctrl

`default_nettype wire

// File: design/shifter_lfsr.sv
`default_nettype none

// shift-left lfsr, xnor feedback into bit 0, taps given at runtime
module shifter_lfsr #(
    parameter int WIDTH           = 16,  // state width
    parameter int TAP_INDEX_WIDTH = 5,   // bits per tap position
    parameter int TAP_COUNT       = 4    // number of tap positions
) (
    input  wire logic                                   i_clk,
    input  wire logic                                   i_rst_n,
    input  wire logic                                   i_enable,     // step or load
    input  wire logic                                   i_seed_load,  // take seed instead
    input  wire logic [WIDTH-1:0]                       i_seed_data,
    input  wire logic [TAP_COUNT*TAP_INDEX_WIDTH-1:0]   i_taps,       // tap 0 in low bits
    output logic      [WIDTH-1:0]                       o_lfsr_out,
    output logic                                        ow_lfsr_done  // state == seed
);
    localparam int TIW = TAP_INDEX_WIDTH;

    logic [WIDTH-1:0] w_mask;      // one bit per tapped position
    logic [WIDTH-1:0] r_lfsr;
    logic             w_feedback;

    ////////////////////
    // tap decode

    always_comb begin
        logic [TIW-1:0] pos;
        w_mask = '0;
        for (int i = 0; i < TAP_COUNT; i++) begin
            pos = i_taps[i*TIW +: TIW];
            // position p selects bit p-1, 0 and out of range ignored
            if ((pos != '0) && (int'(pos) <= WIDTH)) begin
                w_mask[int'(pos) - 1] = 1'b1;
            end
        end
    end

    assign w_feedback = ~^(r_lfsr & w_mask);  // xnor of tapped bits

    ////////////////////
    // state

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_lfsr <= '0;
        end else if (i_enable) begin
            if (i_seed_load) begin
                r_lfsr <= i_seed_data;
            end else begin
                r_lfsr <= {r_lfsr[WIDTH-2:0], w_feedback};  // shift left
            end
        end
    end

    assign o_lfsr_out   = r_lfsr;
    assign ow_lfsr_done = (r_lfsr == i_seed_data);  // combinational wrap flag

endmodule : shifter_lfsr

`default_nettype wire

// File: dv/prbs_bist_patterns.txt
// columns: mode seed taps count inj_a inj_b, all hex, mode f ends the list
// taps hold five bits per position with tap 0 lowest, inj ffff means no injection
// clean runs
0 ace1 235f0 0040 ffff ffff
0 0f0f 5b5d0 0018 ffff ffff
// one and two corrupted words
0 1234 235f0 0080 0005 ffff
0 beef 235f0 0100 0030 0011
0 0001 5b5d0 0020 001f ffff
// nothing to send
0 5555 235f0 0000 0000 ffff
// period mode, full maximal sequence with one error inside
1 ace1 235f0 ffff 0100 ffff
// taps 4,3 never come back to this seed
1 ace1 00064 0028 ffff ffff
// period of two, second injection falls past the wrap
1 5555 00001 0010 0001 0005
1 c0de 235f0 0010 0020 ffff
// back to back with new seeds and taps
0 f00d 235f0 0018 ffff ffff
0 3c3c 00064 0018 ffff ffff
f 0 0 0 0 0

// File: dv/prbs_bist_tb.sv
`default_nettype none

module prbs_bist_tb;
    import prbs_bist_pkg::*;

    localparam int          MAX_TESTS = 32;
    localparam int          FIELDS    = 6;        // hex words per pattern line
    localparam logic [15:0] NO_INJ    = 16'hffff;

    logic              clk;
    logic              rst_n;
    logic              cmd_req;
    test_cmd_t         cmd;
    logic              cmd_ack;
    logic              res_req;
    logic              res_ack;
    test_result_t      res;
    logic              tx_valid;
    logic [LFSR_W-1:0] tx_data;
    logic [LFSR_W-1:0] rx_data;

    logic [31:0]      pat_mem [0:MAX_TESTS*FIELDS-1];
    test_cmd_t        cmds    [0:MAX_TESTS-1];
    logic [CNT_W-1:0] inj_a   [0:MAX_TESTS-1];
    logic [CNT_W-1:0] inj_b   [0:MAX_TESTS-1];
    int               num_tests;

    // shared with the link monitor
    string                  cur_name;
    logic [LFSR_W-1:0]      mdl_state;     // next expected tx word
    logic [TAP_N*TAP_W-1:0] mdl_taps;
    logic [CNT_W-1:0]       cur_inj_a;
    logic [CNT_W-1:0]       cur_inj_b;
    int                     word_idx;
    logic [31:0]            rng;
    int                     err_total;
    int                     test_fails;
    int                     passed;
    logic                   busy;          // cmd accepted and result not yet returned
    logic                   res_seen;
    logic                   prev_ack;
    logic                   prev_res_req;
    logic                   cmd_pending;   // next request already raised
    logic                   wd_armed;
    longint                 wd_limit;

    prbs_bist_top dut (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_cmd_req  (cmd_req),
        .i_cmd      (cmd),
        .o_cmd_ack  (cmd_ack),
        .o_res_req  (res_req),
        .i_res_ack  (res_ack),
        .o_res      (res),
        .o_tx_valid (tx_valid),
        .o_tx_data  (tx_data),
        .i_rx_data  (rx_data)
    );

    always #5 clk = ~clk;

    ////////////////////
    // reference model

    function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] s,
                                                    input logic [TAP_N*TAP_W-1:0] taps);
        int   p;
        logic x;
        x = 1'b0;
        for (int i = 0; i < TAP_N; i++) begin
            p = int'(taps[i*TAP_W +: TAP_W]);
            if (p >= 1 && p <= LFSR_W) x ^= s[p-1];  // tap p is bit p-1
        end
        return {s[LFSR_W-2:0], ~x};  // xnor into bit 0
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] v);
        logic [31:0] x;
        x = v;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // expected length, wrap flag and error counts of one command
    task automatic predict(input test_cmd_t c, input logic [CNT_W-1:0] ia,
                           input logic [CNT_W-1:0] ib, output logic wrapped,
                           output logic [CNT_W-1:0] steps, output logic [CNT_W-1:0] errs,
                           output logic [CNT_W-1:0] first);
        logic [LFSR_W-1:0] s;
        s       = c.seed;
        wrapped = 1'b0;
        steps   = c.count;
        for (int k = 1; k <= int'(c.count); k++) begin
            s = lfsr_next(s, c.taps);
            if (c.mode == MODE_PERIOD && s == c.seed) begin
                wrapped = 1'b1;
                steps   = CNT_W'(k);
                break;
            end
        end
        errs  = '0;
        first = NO_ERR;
        if (ia != NO_INJ && ia < steps) begin
            errs++;
            first = ia;
        end
        if (ib != NO_INJ && ib < steps) begin
            errs++;
            if (ib < first) first = ib;  // lower index wins
        end
    endtask

    ////////////////////
    // checks

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            err_total++;
            test_fails++;
        end
    endtask

    task automatic protocol_error(input string msg);
        $display("%s: %s", cur_name, msg);
        err_total++;
        test_fails++;
    endtask

    task automatic load_patterns();
        int b;
        $readmemh("dv/prbs_bist_patterns.txt", pat_mem);
        num_tests = 0;
        wd_limit  = 0;
        for (int t = 0; t < MAX_TESTS; t++) begin
            b = t * FIELDS;
            if (pat_mem[b] == 32'hf) break;  // end marker
            cmds[t].mode  = bist_mode_e'(pat_mem[b][0]);
            cmds[t].seed  = pat_mem[b+1][LFSR_W-1:0];
            cmds[t].taps  = pat_mem[b+2][TAP_N*TAP_W-1:0];
            cmds[t].count = pat_mem[b+3][CNT_W-1:0];
            inj_a[t]      = pat_mem[b+4][CNT_W-1:0];
            inj_b[t]      = pat_mem[b+5][CNT_W-1:0];
            wd_limit += (longint'(cmds[t].count) + 20) * 10 * 2;
            num_tests++;
        end
    endtask

    ////////////////////
    // host side

    task automatic issue_command(input int t);
        cmd       <= cmds[t];
        cmd_req   <= 1'b1;
        cur_name   = $sformatf("t%0d_%s", t, cmds[t].mode == MODE_PERIOD ? "period" : "run");
        mdl_state  = cmds[t].seed;  // word 0 is the seed
        mdl_taps   = cmds[t].taps;
        cur_inj_a  = inj_a[t];
        cur_inj_b  = inj_b[t];
        word_idx   = 0;
        test_fails = 0;
    endtask

    task automatic run_test(input int t);
        logic             exp_wrapped;
        logic [CNT_W-1:0] exp_steps;
        logic [CNT_W-1:0] exp_errs;
        logic [CNT_W-1:0] exp_first;
        test_result_t     got;
        predict(cmds[t], inj_a[t], inj_b[t], exp_wrapped, exp_steps, exp_errs, exp_first);
        if (!cmd_pending) issue_command(t);
        cmd_pending = 1'b0;
        while (!cmd_ack) @(negedge clk);
        repeat (2) @(negedge clk);  // req held on, ack has to stay up
        cmd_req <= 1'b0;
        while (cmd_ack) @(negedge clk);
        while (!res_req) @(negedge clk);
        got = res;
        check_value("tx words", 32'(exp_steps), 32'(word_idx));
        check_value("wrapped", 32'(exp_wrapped), 32'(got.wrapped));
        check_value("steps", 32'(exp_steps), 32'(got.steps));
        check_value("err_count", 32'(exp_errs), 32'(got.err_count));
        check_value("first_err", 32'(exp_first), 32'(got.first_err));
        $display("test %s: %s, %0d words", cur_name, test_fails == 0 ? "ok" : "FAILED", word_idx);
        if (test_fails == 0) passed++;
        // next request goes up early and its ack has to wait for the result handshake
        if (t + 1 < num_tests) begin
            issue_command(t + 1);
            cmd_pending = 1'b1;
            repeat (3) @(negedge clk);
        end
        res_ack <= 1'b1;
        while (res_req) @(negedge clk);
        res_ack <= 1'b0;
    endtask

    ////////////////////
    // link monitor with loopback and handshake order

    always @(negedge clk) begin : link_monitor
        logic [LFSR_W-1:0] flip;
        flip = '0;
        if (rst_n) begin
            if (tx_valid) begin
                check_value($sformatf("tx word %0d", word_idx), 32'(mdl_state), 32'(tx_data));
                if (word_idx == int'(cur_inj_a) || word_idx == int'(cur_inj_b)) begin
                    rng  = xorshift32(rng);
                    flip = LFSR_W'(1) << rng[3:0];  // one random bit
                end
                mdl_state = lfsr_next(mdl_state, mdl_taps);
                word_idx++;
            end
            if (cmd_ack && !prev_ack) begin
                if (!cmd_req) protocol_error("acknowledge rose without a command request");
                if (busy) protocol_error("acknowledge rose before the result handshake finished");
                busy     = 1'b1;
                res_seen = 1'b0;
            end
            if (!cmd_ack && prev_ack && cmd_req) begin
                protocol_error("acknowledge dropped while the request was still high");
            end
            if (res_req) res_seen = 1'b1;
            if (!res_req && prev_res_req && !res_ack) begin
                protocol_error("result request dropped before the host acknowledged");
            end
            if (busy && res_seen && !res_req && !res_ack) busy = 1'b0;  // back to zero
        end
        rx_data      <= tx_data ^ flip;  // no loop delay
        prev_ack      = cmd_ack;
        prev_res_req  = res_req;
    end

    initial begin : watchdog
        wait (wd_armed);
        #(wd_limit);
        $display("watchdog expired, run did not finish within %0d time units", wd_limit);
        $display("Test failures found");
        $finish;
    end

    ////////////////////
    // main sequence

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        cmd_req      = 1'b0;
        cmd          = '0;
        res_ack      = 1'b0;
        rx_data      = '0;
        rng          = 32'h7cbb;
        err_total    = 0;
        test_fails   = 0;
        passed       = 0;
        busy         = 1'b0;
        res_seen     = 1'b0;
        prev_ack     = 1'b0;
        prev_res_req = 1'b0;
        cmd_pending  = 1'b0;
        word_idx     = 0;
        cur_name     = "reset";
        load_patterns();
        wd_armed = 1'b1;
        repeat (5) @(negedge clk);  // five cycles in reset
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("cmd_ack", 0, 32'(cmd_ack));
        check_value("res_req", 0, 32'(res_req));
        check_value("tx_valid", 0, 32'(tx_valid));
        check_value("lfsr state", 0, 32'(tx_data));
        $display("test reset: %s", test_fails == 0 ? "ok" : "FAILED");
        if (num_tests == 0) protocol_error("pattern file holds no tests");
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        @(negedge clk);
        $display("%0d tests run, %0d passed, %0d failed, %0d errors",
                 num_tests, passed, num_tests - passed, err_total);
        if (err_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : prbs_bist_tb

`default_nettype wire

// File: prbs_bist.f
design/prbs_bist_pkg.sv
design/shifter_lfsr.sv
design/prbs_ctrl.sv
design/prbs_checker.sv
design/prbs_bist_top.sv
dv/prbs_bist_tb.sv
